// File: sources.f
hw/ice_basics_pkg.sv
hw/cmd_capture.sv
hw/ack_generator.sv
hw/param_regs.sv
hw/basics_fsm.sv
hw/message_fifo.sv
hw/ice_basics.sv
dv/tb_clock.sv
dv/tb_ice_basics.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ice_basics \
	-f sources.f -Mdir obj_dir -o sim_ice_basics
./obj_dir/sim_ice_basics | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: dv/tb_ice_basics.sv
module tb_ice_basics;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W = 6;
	localparam int N = 12;
	localparam int LIMIT = N * 200;
	localparam logic [23:0] GPIO_IN = 24'h5A_C3_81;

	logic clk;
	logic rst;
	logic generate_nak;
	logic [7:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic [ADDR_W-1:0] out_addr;
	logic [8:0] out_data;
	logic latch_tail;
	logic frame_pending;
	logic [7:0] i2c_speed;
	logic [15:0] i2c_addr;
	logic [ice_basics_pkg::GPIO_W-1:0] gpio_read;
	logic [ice_basics_pkg::GPIO_W-1:0] gpio_level;
	logic [ice_basics_pkg::GPIO_W-1:0] gpio_direction;
	logic [ice_basics_pkg::GPIO_W-1:0] gpio_int_enable;

	// Stimulus and expected replies, one row per request
	logic t_nak [N];
	int t_in_len [N];
	logic [7:0] t_in [N][8];
	int t_nfrm [N];
	int t_flen [N][2];
	logic [7:0] t_frm [N][2][3];
	logic [7:0] t_speed [N];
	logic [15:0] t_addr [N];
	logic [23:0] t_level [N];
	logic [23:0] t_dir [N];
	logic [23:0] t_int [N];

	// Reference model of the settings
	logic [7:0] m_speed;
	logic [15:0] m_addr;
	logic [23:0] m_level;
	logic [23:0] m_dir;
	logic [23:0] m_int;
	logic [23:0] old_level;
	logic [23:0] old_dir;
	logic [23:0] old_int;

	int seed = 32'h37f0_4280;
	int n_entries = 0;
	int value_errors = 0;
	int timeouts = 0;
	int cycles = 0;

	tb_clock #(.PERIOD(8), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst(rst));

	ice_basics #(.FIFO_ADDR_W(ADDR_W)) DUT (.*);

	task automatic byte_compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic flag_compare(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic addr_compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic gpio_compare(input string name, input logic [ice_basics_pkg::GPIO_W-1:0] exp,
		input logic [ice_basics_pkg::GPIO_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic open_entry(input logic nak);
		t_nak[n_entries] = nak;
		t_in_len[n_entries] = 0;
		t_nfrm[n_entries] = 0;
		t_flen[n_entries][0] = 0;
		t_flen[n_entries][1] = 0;
	endtask

	task automatic push_in(input logic [7:0] b);
		t_in[n_entries][t_in_len[n_entries]] = b;
		t_in_len[n_entries]++;
	endtask

	task automatic push_reply(input int f, input logic [7:0] b);
		t_frm[n_entries][f][t_flen[n_entries][f]] = b;
		t_flen[n_entries][f]++;
		if (f + 1 > t_nfrm[n_entries])
			t_nfrm[n_entries] = f + 1;
	endtask

	// ACK and NAK frames are code, EID, zero length
	task automatic ack_reply(input int f, input logic [7:0] code, input logic [7:0] eid);
		push_reply(f, code);
		push_reply(f, eid);
		push_reply(f, 8'h00);
	endtask

	task automatic close_entry();
		t_speed[n_entries] = m_speed;
		t_addr[n_entries] = m_addr;
		t_level[n_entries] = m_level;
		t_dir[n_entries] = m_dir;
		t_int[n_entries] = m_int;
		n_entries++;
	endtask

	task automatic nak_entry();
		logic [7:0] eid;
		eid = 8'($random(seed));
		open_entry(1'b1);
		push_in(eid);
		push_in(8'h00);
		ack_reply(0, ice_basics_pkg::RESP_NAK, eid);
		close_entry();
	endtask

	task automatic version_entry(input logic [7:0] major, input logic [7:0] minor);
		logic [7:0] eid;
		eid = 8'($random(seed));
		open_entry(1'b0);
		push_in(ice_basics_pkg::OP_VER);
		push_in(eid);
		push_in(8'd2);
		push_in(major);
		push_in(minor);
		if (major == 8'h00 && minor == 8'h03)
			ack_reply(0, ice_basics_pkg::RESP_ACK, eid);
		else begin
			ack_reply(0, ice_basics_pkg::RESP_NAK, eid);
			push_reply(1, 8'h00);
			push_reply(1, 8'h03);
		end
		close_entry();
	endtask

	task automatic set_entry(input logic [7:0] op, input logic [7:0] sub, input int nbytes,
		input logic [23:0] value);
		logic [7:0] eid;
		eid = 8'($random(seed));
		open_entry(1'b0);
		push_in(op);
		push_in(eid);
		push_in(8'(nbytes + 1));
		push_in(sub);
		for (int i = nbytes - 1; i >= 0; i--)
			push_in(value[8*i +: 8]);
		ack_reply(0, ice_basics_pkg::RESP_ACK, eid);
		if (op == ice_basics_pkg::OP_I2C_SET && sub == ice_basics_pkg::SUB_SPEED)
			m_speed = value[7:0];
		else if (op == ice_basics_pkg::OP_I2C_SET && sub == ice_basics_pkg::SUB_ADDR)
			m_addr = value[15:0];
		else if (op == ice_basics_pkg::OP_GPIO_SET && sub == ice_basics_pkg::SUB_LEVEL)
			m_level = value;
		else if (op == ice_basics_pkg::OP_GPIO_SET && sub == ice_basics_pkg::SUB_DIR)
			m_dir = value;
		else if (op == ice_basics_pkg::OP_GPIO_SET && sub == ice_basics_pkg::SUB_INT)
			m_int = value;
		close_entry();
	endtask

	task automatic query_entry(input logic [7:0] op, input logic [7:0] sub);
		logic [7:0] eid;
		logic [23:0] value;
		int nbytes;
		eid = 8'($random(seed));
		value = '0;
		nbytes = 1;
		// Unknown selector answers with a single zero byte
		if (op == ice_basics_pkg::OP_I2C_QUERY && sub == ice_basics_pkg::SUB_SPEED)
			value = {16'h0000, m_speed};
		else if (op == ice_basics_pkg::OP_I2C_QUERY && sub == ice_basics_pkg::SUB_ADDR) begin
			value = {8'h00, m_addr};
			nbytes = 2;
		end else if (op == ice_basics_pkg::OP_GPIO_QUERY) begin
			nbytes = 3;
			if (sub == ice_basics_pkg::SUB_LEVEL)
				value = GPIO_IN;
			else if (sub == ice_basics_pkg::SUB_DIR)
				value = m_dir;
			else if (sub == ice_basics_pkg::SUB_INT)
				value = m_int;
			else
				nbytes = 1;
		end
		open_entry(1'b0);
		push_in(op);
		push_in(eid);
		push_in(8'd1);
		push_in(sub);
		ack_reply(0, ice_basics_pkg::RESP_ACK, eid);
		for (int i = nbytes - 1; i >= 0; i--)
			push_reply(1, value[8*i +: 8]);
		close_entry();
	endtask

	task automatic unknown_entry(input logic [7:0] op);
		open_entry(1'b0);
		push_in(op);
		push_in(8'($random(seed)));
		push_in(8'd1);
		push_in(8'h55);
		close_entry();
	endtask

	task automatic drive_entry(input int e);
		if (t_nak[e]) begin
			@(posedge clk);
			generate_nak <= 1'b1;
			@(posedge clk);
			generate_nak <= 1'b0;
		end
		for (int i = 0; i < t_in_len[e]; i++) begin
			@(posedge clk);
			ma_data <= t_in[e][i];
			ma_data_valid <= 1'b1;
			ma_frame_valid <= !t_nak[e];
		end
		@(posedge clk);
		ma_data <= 8'h00;
		ma_data_valid <= 1'b0;
		ma_frame_valid <= 1'b0;
	endtask

	// Reader model, one entry per cycle until the last flag
	task automatic read_frame(input int e, input int f);
		@(negedge clk);
		while (frame_pending !== 1'b1)
			@(negedge clk);
		for (int i = 0; i < t_flen[e][f]; i++) begin
			@(posedge clk);
			out_addr <= ADDR_W'(i);
			@(negedge clk);
			byte_compare("out_data[7:0]", t_frm[e][f][i], out_data[7:0]);
			flag_compare("out_data[8]", (i == t_flen[e][f] - 1), out_data[8]);
		end
		// GPIO outputs hold their old values until the first frame is released
		if (f == 0) begin
			gpio_compare("gpio_level", old_level, gpio_level);
			gpio_compare("gpio_direction", old_dir, gpio_direction);
			gpio_compare("gpio_int_enable", old_int, gpio_int_enable);
		end
		@(posedge clk);
		latch_tail <= 1'b1;
		out_addr <= '0;
		@(posedge clk);
		latch_tail <= 1'b0;
	endtask

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		timeouts++;
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Summary: %0d value errors, %0d timeouts", value_errors, timeouts);
		$display("Errors found");
		$finish;
	end

	initial begin
		generate_nak <= 1'b0;
		ma_data <= 8'h00;
		ma_data_valid <= 1'b0;
		ma_frame_valid <= 1'b0;
		out_addr <= '0;
		latch_tail <= 1'b0;
		gpio_read <= GPIO_IN;
		m_speed = 8'd99;
		m_addr = 16'hFFFF;
		m_level = '0;
		m_dir = '0;
		m_int = '0;
		old_level = '0;
		old_dir = '0;
		old_int = '0;

		nak_entry();
		version_entry(8'h00, 8'h03);
		version_entry(8'h00, 8'h02);
		set_entry(ice_basics_pkg::OP_I2C_SET, ice_basics_pkg::SUB_SPEED, 1, 24'h00002A);
		set_entry(ice_basics_pkg::OP_I2C_SET, ice_basics_pkg::SUB_ADDR, 2, 24'h00A53C);
		query_entry(ice_basics_pkg::OP_I2C_QUERY, ice_basics_pkg::SUB_SPEED);
		query_entry(ice_basics_pkg::OP_I2C_QUERY, ice_basics_pkg::SUB_ADDR);
		set_entry(ice_basics_pkg::OP_GPIO_SET, ice_basics_pkg::SUB_DIR, 3, 24'h123456);
		query_entry(ice_basics_pkg::OP_GPIO_QUERY, ice_basics_pkg::SUB_DIR);
		query_entry(ice_basics_pkg::OP_GPIO_QUERY, ice_basics_pkg::SUB_LEVEL);
		unknown_entry(8'h78);
		query_entry(ice_basics_pkg::OP_I2C_QUERY, 8'h7A);

		while (rst !== 1'b0)
			@(negedge clk);
		@(negedge clk);
		byte_compare("i2c_speed", 8'd99, i2c_speed);
		addr_compare("i2c_addr", 16'hFFFF, i2c_addr);
		gpio_compare("gpio_level", '0, gpio_level);
		gpio_compare("gpio_direction", '0, gpio_direction);
		gpio_compare("gpio_int_enable", '0, gpio_int_enable);
		flag_compare("frame_pending", 1'b0, frame_pending);

		for (int e = 0; e < n_entries; e++) begin
			drive_entry(e);
			for (int f = 0; f < t_nfrm[e]; f++)
				read_frame(e, f);
			// Room for a late frame or a staged GPIO update
			repeat (16) @(negedge clk);
			flag_compare("frame_pending", 1'b0, frame_pending);
			byte_compare("i2c_speed", t_speed[e], i2c_speed);
			addr_compare("i2c_addr", t_addr[e], i2c_addr);
			gpio_compare("gpio_level", t_level[e], gpio_level);
			gpio_compare("gpio_direction", t_dir[e], gpio_direction);
			gpio_compare("gpio_int_enable", t_int[e], gpio_int_enable);
			old_level = t_level[e];
			old_dir = t_dir[e];
			old_int = t_int[e];
		end

		$display("Summary: %0d value errors, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: dv/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held high for the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: hw/ice_basics.sv
module ice_basics #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h03,
	parameter int FIFO_ADDR_W = 6
) (
	input logic clk,
	input logic rst,
	input logic generate_nak,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	input logic [FIFO_ADDR_W-1:0] out_addr,
	output logic [8:0] out_data,
	input logic latch_tail,
	output logic frame_pending,
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,
	input logic [ice_basics_pkg::GPIO_W-1:0] gpio_read,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_level,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_direction,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_int_enable
);
	ice_basics_pkg::cmd_t cmd;
	logic cmd_new;
	logic gen_ack;
	logic gen_nak;
	logic [7:0] eid;
	logic store_query;
	logic store_set;
	logic shift_query;
	logic shift_set;
	logic latch_temps;
	logic [7:0] staging_byte;
	logic last_byte;
	logic set_done;
	logic [7:0] ack_data;
	logic ack_valid;
	logic ack_frame;
	logic [7:0] local_data;
	logic local_valid;
	logic local_frame;

	cmd_capture u_capture (.*);

	basics_fsm #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) u_fsm (
		.generate_ack(gen_ack),
		.generate_nak(gen_nak),
		.*
	);

	param_regs u_params (.*);

	ack_generator u_ack (
		.generate_ack(gen_ack),
		.generate_nak(gen_nak),
		.*
	);

	// ACK bytes take the buffer write port ahead of local bytes
	message_fifo #(
		.FIFO_ADDR_W(FIFO_ADDR_W)
	) u_fifo (
		.in_data(ack_valid ? ack_data : local_data),
		.in_valid(ack_valid | local_valid),
		.in_frame(ack_frame | local_frame),
		.*
	);

endmodule

// File: hw/message_fifo.sv
module message_fifo #(
	parameter int FIFO_ADDR_W = 6
) (
	input logic clk,
	input logic rst,
	input logic [7:0] in_data,
	input logic in_valid,
	input logic in_frame,
	input logic [FIFO_ADDR_W-1:0] out_addr,
	output logic [8:0] out_data,
	output logic frame_pending,
	input logic latch_tail
);
	localparam int DEPTH = 2 ** FIFO_ADDR_W;

	logic [7:0] mem [DEPTH];
	logic last_flag [DEPTH];
	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W-1:0] end_ptr;
	logic [FIFO_ADDR_W-1:0] tail;
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic [FIFO_ADDR_W-1:0] idx;
	logic [FIFO_ADDR_W-1:0] oldest_end;
	logic [FIFO_ADDR_W:0] frame_count;
	logic frame_open;
	logic frame_close;
	logic found;
	logic release_frame;

	// Frame closes when the input level drops after at least one byte
	assign frame_close = frame_open && !in_frame;
	assign release_frame = latch_tail && frame_pending;
	assign rd_ptr = tail + out_addr;
	assign out_data = {last_flag[rd_ptr], mem[rd_ptr]};
	assign frame_pending = (frame_count != '0);

	// First last flag at or after tail ends the oldest frame
	always_comb begin
		oldest_end = tail;
		found = 1'b0;
		idx = tail;
		for (int i = 0; i < DEPTH; i++) begin
			idx = tail + FIFO_ADDR_W'(i);
			if (!found && last_flag[idx]) begin
				oldest_end = idx;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
			last_flag[wr_ptr] <= 1'b0;
		end
		if (frame_close)
			last_flag[end_ptr] <= 1'b1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			end_ptr <= '0;
			tail <= '0;
			frame_count <= '0;
			frame_open <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + FIFO_ADDR_W'(1);
				end_ptr <= wr_ptr;
			end
			if (in_valid)
				frame_open <= 1'b1;
			else if (!in_frame)
				frame_open <= 1'b0;
			if (release_frame)
				tail <= oldest_end + FIFO_ADDR_W'(1);
			if (frame_close && !release_frame)
				frame_count <= frame_count + (FIFO_ADDR_W + 1)'(1);
			else if (release_frame && !frame_close)
				frame_count <= frame_count - (FIFO_ADDR_W + 1)'(1);
		end
	end

	// Reader must drain frames before the write pointer wraps onto tail
	assert property (@(posedge clk) disable iff (rst)
		in_valid |-> (wr_ptr + FIFO_ADDR_W'(1) != tail));

endmodule

// File: hw/basics_fsm.sv
module basics_fsm #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h03
) (
	input logic clk,
	input logic rst,
	input ice_basics_pkg::cmd_t cmd,
	input logic cmd_new,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ack_frame,
	input logic frame_pending,
	input logic [7:0] staging_byte,
	input logic last_byte,
	input logic set_done,
	output logic generate_ack,
	output logic generate_nak,
	output logic [7:0] eid,
	output logic store_query,
	output logic store_set,
	output logic shift_query,
	output logic shift_set,
	output logic latch_temps,
	output logic [7:0] local_data,
	output logic local_valid,
	output logic local_frame
);
	ice_basics_pkg::state_t state;
	ice_basics_pkg::state_t next_state;
	ice_basics_pkg::cmd_t cmd_q;
	logic [15:0] ver_in;
	logic ver_cnt;
	logic latch_eid;
	logic ver_shift;

	// EID may follow the command byte in the very next cycle
	assign latch_eid = ma_data_valid && ((state == ice_basics_pkg::ST_IDLE && cmd_new) ||
		state == ice_basics_pkg::ST_LATCH_EID);
	assign ver_shift = ma_data_valid && (state == ice_basics_pkg::ST_VER_SHIFT);

	assign store_query = (state == ice_basics_pkg::ST_QUERY_SEL);
	assign store_set = (state == ice_basics_pkg::ST_SET_SEL);
	assign shift_query = (state == ice_basics_pkg::ST_QUERY_SEND);
	assign shift_set = (state == ice_basics_pkg::ST_SET_SHIFT) && !set_done;
	assign latch_temps = (state == ice_basics_pkg::ST_SET_APPLY) && !frame_pending;

	assign local_frame = (state == ice_basics_pkg::ST_VER_MAJOR) ||
		(state == ice_basics_pkg::ST_VER_MINOR) || (state == ice_basics_pkg::ST_QUERY_SEND);
	assign local_valid = local_frame;
	assign local_data = (state == ice_basics_pkg::ST_VER_MAJOR) ? VERSION_MAJOR :
		(state == ice_basics_pkg::ST_VER_MINOR) ? VERSION_MINOR : staging_byte;

	always_comb begin
		next_state = state;
		generate_ack = 1'b0;
		generate_nak = 1'b0;
		case (state)
			ice_basics_pkg::ST_IDLE:
				if (cmd_new)
					next_state = ma_data_valid ? ice_basics_pkg::ST_SKIP_LEN :
						ice_basics_pkg::ST_LATCH_EID;
			ice_basics_pkg::ST_LATCH_EID:
				if (ma_data_valid)
					next_state = ice_basics_pkg::ST_SKIP_LEN;
			ice_basics_pkg::ST_SKIP_LEN:
				if (ma_data_valid) begin
					case (cmd_q)
						ice_basics_pkg::CMD_NAK: next_state = ice_basics_pkg::ST_NAK;
						ice_basics_pkg::CMD_VER: next_state = ice_basics_pkg::ST_VER_SHIFT;
						ice_basics_pkg::CMD_I2C_QUERY,
						ice_basics_pkg::CMD_GPIO_QUERY: next_state = ice_basics_pkg::ST_QUERY_SEL;
						ice_basics_pkg::CMD_I2C_SET,
						ice_basics_pkg::CMD_GPIO_SET: next_state = ice_basics_pkg::ST_SET_SEL;
						default: next_state = ice_basics_pkg::ST_IDLE;
					endcase
				end
			ice_basics_pkg::ST_NAK: begin
				generate_nak = 1'b1;
				next_state = ice_basics_pkg::ST_IDLE;
			end
			ice_basics_pkg::ST_VER_SHIFT:
				if (ver_shift && ver_cnt)
					next_state = ice_basics_pkg::ST_VER_CHECK;
			ice_basics_pkg::ST_VER_CHECK:
				if (ver_in == {VERSION_MAJOR, VERSION_MINOR}) begin
					generate_ack = 1'b1;
					next_state = ice_basics_pkg::ST_IDLE;
				end else begin
					// Mismatch reports the real version after the NAK
					generate_nak = 1'b1;
					next_state = ice_basics_pkg::ST_WAIT_ACK;
				end
			ice_basics_pkg::ST_WAIT_ACK:
				if (!ack_frame)
					next_state = (cmd_q == ice_basics_pkg::CMD_VER) ?
						ice_basics_pkg::ST_VER_MAJOR : ice_basics_pkg::ST_QUERY_SEND;
			ice_basics_pkg::ST_VER_MAJOR: next_state = ice_basics_pkg::ST_VER_MINOR;
			ice_basics_pkg::ST_VER_MINOR: next_state = ice_basics_pkg::ST_IDLE;
			ice_basics_pkg::ST_QUERY_SEL:
				if (ma_data_valid) begin
					generate_ack = 1'b1;
					next_state = ice_basics_pkg::ST_WAIT_ACK;
				end
			ice_basics_pkg::ST_QUERY_SEND:
				if (last_byte)
					next_state = ice_basics_pkg::ST_IDLE;
			ice_basics_pkg::ST_SET_SEL:
				if (ma_data_valid)
					next_state = ice_basics_pkg::ST_SET_SHIFT;
			ice_basics_pkg::ST_SET_SHIFT:
				if (set_done) begin
					generate_ack = 1'b1;
					// Only GPIO changes wait for the reader to take the ACK
					next_state = (cmd_q == ice_basics_pkg::CMD_GPIO_SET) ?
						ice_basics_pkg::ST_SET_WAIT : ice_basics_pkg::ST_IDLE;
				end
			ice_basics_pkg::ST_SET_WAIT:
				if (frame_pending)
					next_state = ice_basics_pkg::ST_SET_APPLY;
			ice_basics_pkg::ST_SET_APPLY:
				if (!frame_pending)
					next_state = ice_basics_pkg::ST_IDLE;
			default: next_state = ice_basics_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ice_basics_pkg::ST_IDLE;
			cmd_q <= ice_basics_pkg::CMD_NONE;
			ver_cnt <= 1'b0;
		end else begin
			state <= next_state;
			if (state == ice_basics_pkg::ST_IDLE && cmd_new)
				cmd_q <= cmd;
			if (ver_shift)
				ver_cnt <= ~ver_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (latch_eid)
			eid <= ma_data;
		if (ver_shift)
			ver_in <= {ver_in[7:0], ma_data};
	end

	// Local bytes are framed and never overlap the ACK frame
	assert property (@(posedge clk) disable iff (rst)
		local_valid |-> (local_frame && !ack_frame));

endmodule

// File: hw/param_regs.sv
module param_regs (
	input logic clk,
	input logic rst,
	input ice_basics_pkg::cmd_t cmd,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic store_query,
	input logic store_set,
	input logic shift_query,
	input logic shift_set,
	input logic latch_temps,
	input logic [ice_basics_pkg::GPIO_W-1:0] gpio_read,
	output logic [7:0] staging_byte,
	output logic last_byte,
	output logic set_done,
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_level,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_direction,
	output logic [ice_basics_pkg::GPIO_W-1:0] gpio_int_enable
);
	ice_basics_pkg::param_sel_t sel;
	ice_basics_pkg::param_sel_t sel_dec;
	logic [1:0] countdown;
	logic [1:0] count_dec;
	logic [ice_basics_pkg::GPIO_W-1:0] staging;
	logic [ice_basics_pkg::GPIO_W-1:0] level_tmp;
	logic [ice_basics_pkg::GPIO_W-1:0] dir_tmp;
	logic [ice_basics_pkg::GPIO_W-1:0] int_tmp;
	logic load_query;
	logic load_set;
	logic take_byte;

	assign load_query = store_query && ma_data_valid;
	assign load_set = store_set && ma_data_valid;
	assign take_byte = shift_set && ma_data_valid;

	// Selector byte decode, qualified by the command family
	always_comb begin
		sel_dec = ice_basics_pkg::SEL_NONE;
		if (cmd == ice_basics_pkg::CMD_I2C_QUERY || cmd == ice_basics_pkg::CMD_I2C_SET) begin
			if (ma_data == ice_basics_pkg::SUB_SPEED)
				sel_dec = ice_basics_pkg::SEL_I2C_SPEED;
			else if (ma_data == ice_basics_pkg::SUB_ADDR)
				sel_dec = ice_basics_pkg::SEL_I2C_ADDR;
		end else if (cmd == ice_basics_pkg::CMD_GPIO_QUERY || cmd == ice_basics_pkg::CMD_GPIO_SET) begin
			if (ma_data == ice_basics_pkg::SUB_LEVEL)
				sel_dec = ice_basics_pkg::SEL_GPIO_LEVEL;
			else if (ma_data == ice_basics_pkg::SUB_DIR)
				sel_dec = ice_basics_pkg::SEL_GPIO_DIR;
			else if (ma_data == ice_basics_pkg::SUB_INT)
				sel_dec = ice_basics_pkg::SEL_GPIO_INT;
		end
		case (sel_dec)
			ice_basics_pkg::SEL_NONE: count_dec = 2'd0;
			ice_basics_pkg::SEL_I2C_SPEED: count_dec = 2'd1;
			ice_basics_pkg::SEL_I2C_ADDR: count_dec = 2'd2;
			default: count_dec = 2'd3;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sel <= ice_basics_pkg::SEL_NONE;
			countdown <= 2'd0;
			i2c_speed <= ice_basics_pkg::I2C_SPEED_RESET;
			i2c_addr <= ice_basics_pkg::I2C_ADDR_RESET;
			gpio_level <= '0;
			gpio_direction <= '0;
			gpio_int_enable <= '0;
		end else begin
			// Unknown query still answers with a single zero byte
			if (load_query)
				countdown <= (sel_dec == ice_basics_pkg::SEL_NONE) ? 2'd1 : count_dec;
			else if (load_set) begin
				sel <= sel_dec;
				countdown <= count_dec;
			end else if (shift_query || take_byte)
				countdown <= countdown - 2'd1;
			if (take_byte) begin
				case (sel)
					ice_basics_pkg::SEL_I2C_SPEED: i2c_speed <= ma_data;
					ice_basics_pkg::SEL_I2C_ADDR: i2c_addr <= {i2c_addr[7:0], ma_data};
					default: ;
				endcase
			end
			if (latch_temps) begin
				case (sel)
					ice_basics_pkg::SEL_GPIO_LEVEL: gpio_level <= level_tmp;
					ice_basics_pkg::SEL_GPIO_DIR: gpio_direction <= dir_tmp;
					ice_basics_pkg::SEL_GPIO_INT: gpio_int_enable <= int_tmp;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_query) begin
			case (sel_dec)
				ice_basics_pkg::SEL_I2C_SPEED: staging <= {i2c_speed, 16'h0000};
				ice_basics_pkg::SEL_I2C_ADDR: staging <= {i2c_addr, 8'h00};
				ice_basics_pkg::SEL_GPIO_LEVEL: staging <= gpio_read;
				ice_basics_pkg::SEL_GPIO_DIR: staging <= gpio_direction;
				ice_basics_pkg::SEL_GPIO_INT: staging <= gpio_int_enable;
				default: staging <= '0;
			endcase
		end else if (shift_query)
			staging <= {staging[ice_basics_pkg::GPIO_W-9:0], 8'h00};
		// GPIO payload collects here until the ACK is released
		if (take_byte) begin
			case (sel)
				ice_basics_pkg::SEL_GPIO_LEVEL: level_tmp <= {level_tmp[15:0], ma_data};
				ice_basics_pkg::SEL_GPIO_DIR: dir_tmp <= {dir_tmp[15:0], ma_data};
				ice_basics_pkg::SEL_GPIO_INT: int_tmp <= {int_tmp[15:0], ma_data};
				default: ;
			endcase
		end
	end

	assign staging_byte = staging[ice_basics_pkg::GPIO_W-1 -: 8];
	assign last_byte = (countdown == 2'd1);
	assign set_done = (countdown == 2'd0);

endmodule

// File: hw/ack_generator.sv
module ack_generator (
	input logic clk,
	input logic rst,
	input logic generate_ack,
	input logic generate_nak,
	input logic [7:0] eid,
	output logic [7:0] ack_data,
	output logic ack_valid,
	output logic ack_frame
);
	logic [1:0] phase;
	logic is_nak;
	logic [7:0] eid_q;

	// Phase 1 code, 2 EID, 3 zero length, then back to idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			phase <= 2'd0;
		else if (generate_ack || generate_nak)
			phase <= 2'd1;
		else if (phase != 2'd0)
			phase <= phase + 2'd1;
	end

	always_ff @(posedge clk) begin
		if (generate_ack || generate_nak) begin
			is_nak <= generate_nak;
			eid_q <= eid;
		end
	end

	always_comb begin
		case (phase)
			2'd1: ack_data = is_nak ? ice_basics_pkg::RESP_NAK : ice_basics_pkg::RESP_ACK;
			2'd2: ack_data = eid_q;
			default: ack_data = 8'h00;
		endcase
	end

	assign ack_valid = (phase != 2'd0);
	assign ack_frame = (phase != 2'd0);

	// A new request must not cut into a frame still being sent
	assert property (@(posedge clk) disable iff (rst)
		(generate_ack || generate_nak) |-> !ack_frame);

endmodule

// File: hw/cmd_capture.sv
module cmd_capture (
	input logic clk,
	input logic rst,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	input logic generate_nak,
	output ice_basics_pkg::cmd_t cmd,
	output logic cmd_new
);
	ice_basics_pkg::cmd_t decoded;
	logic frame_q;
	logic frame_start;

	// First byte of a frame arrives with the rising frame level
	assign frame_start = ma_frame_valid && !frame_q && ma_data_valid;

	always_comb begin
		case (ma_data)
			ice_basics_pkg::OP_VER: decoded = ice_basics_pkg::CMD_VER;
			ice_basics_pkg::OP_I2C_QUERY: decoded = ice_basics_pkg::CMD_I2C_QUERY;
			ice_basics_pkg::OP_I2C_SET: decoded = ice_basics_pkg::CMD_I2C_SET;
			ice_basics_pkg::OP_GPIO_QUERY: decoded = ice_basics_pkg::CMD_GPIO_QUERY;
			ice_basics_pkg::OP_GPIO_SET: decoded = ice_basics_pkg::CMD_GPIO_SET;
			default: decoded = ice_basics_pkg::CMD_NONE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_q <= 1'b0;
			cmd <= ice_basics_pkg::CMD_NONE;
			cmd_new <= 1'b0;
		end else begin
			frame_q <= ma_frame_valid;
			cmd_new <= 1'b0;
			// Immediate NAK request wins over a frame start
			if (generate_nak) begin
				cmd <= ice_basics_pkg::CMD_NAK;
				cmd_new <= 1'b1;
			end else if (frame_start) begin
				cmd <= decoded;
				cmd_new <= (decoded != ice_basics_pkg::CMD_NONE);
			end
		end
	end

endmodule

// File: hw/ice_basics_pkg.sv
package ice_basics_pkg;

	localparam int GPIO_W = 24;

	// Command bytes
	localparam logic [7:0] OP_VER = "v";
	localparam logic [7:0] OP_I2C_QUERY = "I";
	localparam logic [7:0] OP_I2C_SET = "i";
	localparam logic [7:0] OP_GPIO_QUERY = "G";
	localparam logic [7:0] OP_GPIO_SET = "g";

	// Register selectors, first payload byte of a query or set
	localparam logic [7:0] SUB_SPEED = "c";
	localparam logic [7:0] SUB_ADDR = "a";
	localparam logic [7:0] SUB_LEVEL = "l";
	localparam logic [7:0] SUB_DIR = "d";
	localparam logic [7:0] SUB_INT = "i";

	localparam logic [7:0] RESP_ACK = 8'h02;
	localparam logic [7:0] RESP_NAK = 8'h03;

	localparam logic [7:0] I2C_SPEED_RESET = 8'd99;
	localparam logic [15:0] I2C_ADDR_RESET = 16'hFFFF;

	typedef enum logic [2:0] {
		CMD_NONE, CMD_NAK, CMD_VER, CMD_I2C_QUERY, CMD_I2C_SET, CMD_GPIO_QUERY, CMD_GPIO_SET
	} cmd_t;

	typedef enum logic [2:0] {
		SEL_NONE, SEL_I2C_SPEED, SEL_I2C_ADDR, SEL_GPIO_LEVEL, SEL_GPIO_DIR, SEL_GPIO_INT
	} param_sel_t;

	typedef enum logic [3:0] {
		ST_IDLE, ST_LATCH_EID, ST_SKIP_LEN, ST_NAK, ST_VER_SHIFT, ST_VER_CHECK, ST_WAIT_ACK,
		ST_VER_MAJOR, ST_VER_MINOR, ST_QUERY_SEL, ST_QUERY_SEND, ST_SET_SEL, ST_SET_SHIFT,
		ST_SET_WAIT, ST_SET_APPLY
	} state_t;

endpackage
